// File: sim.f
+incdir+include
src/lsu_pkg.sv
src/ls_decode.sv
src/agu.sv
src/loadstore_unit.sv
src/dmem_extender.sv
src/lsu_top.sv
tests/lsu_chk.sv
tests/lsu_tb.sv

// File: tests/lsu_tb.sv
// testbench for lsu_top, random issues against a wait-state memory and a reference model
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_tb import lsu_pkg::*; ();

  localparam int NUM_ISSUES = 2000;
  localparam int CLK_PERIOD = 10;
  localparam int MEM_WORDS  = 64;

  typedef struct packed {
    logic                  is_store;
    logic                  mal;
    logic [2:0]            f3;
    logic [`WORD_W-1:0]    addr;
    logic [`BYTE_EN_W-1:0] byte_en;
    logic [`WORD_W-1:0]    wdata;     // replicated store data
    logic                  wen;
    logic [`REG_W-1:0]     reg_rd;
    logic [`CB_IDX_W-1:0]  index;
    logic [`WORD_W-1:0]    pc;
  } expect_t;

  logic               CLK = 1'b0;
  logic               nRST;
  logic               halt;
  logic               flush;
  ls_issue_t          issue;
  logic [`WORD_W-1:0] bus_rdata;
  logic               bus_busy;
  dbus_req_t          bus_req;
  logic               busy;
  ls_result_t         result;

  integer seed = 32'h95a19029;
  logic [`WORD_W-1:0] mem     [MEM_WORDS];   // bus side memory
  logic [`WORD_W-1:0] ref_mem [MEM_WORDS];   // model copy
  logic [1:0] wait_left;                    // wait states left on the current request
  logic [1:0] next_wait;
  expect_t    exp_q[$];                     // completions still owed, oldest first
  int age = 0;                              // negedges the oldest entry has waited
  int errors = 0;
  int sent = 0;
  int loads = 0;
  int stores = 0;
  int misaligned = 0;
  int dropped = 0;

  lsu_top dut (
    .CLK       (CLK),
    .nRST      (nRST),
    .halt      (halt),
    .flush     (flush),
    .issue     (issue),
    .bus_rdata (bus_rdata),
    .bus_busy  (bus_busy),
    .bus_req   (bus_req),
    .busy      (busy),
    .result    (result)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  task automatic report_error(input string msg);
    errors++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  function automatic logic [`WORD_W-1:0] fill_word(input int i);
    logic [`WORD_W-1:0] w;
    w = i;
    return ((w + 1) * 32'h9e3779b9) ^ (w << 12);   // every address bit matters
  endfunction

  function automatic logic is_legal(input ls_issue_t iss);
    if (!iss.ena) return 1'b0;
    if (iss.opcode == OP_LOAD) return iss.funct3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    if (iss.opcode == OP_STORE) return iss.funct3 <= 3'd2;
    return 1'b0;   // other opcodes never reach the bus
  endfunction

  function automatic expect_t predict(input ls_issue_t iss);
    expect_t            e;
    logic [`WORD_W-1:0] a;
    logic [`WORD_W-1:0] d;
    a = iss.port_a + iss.port_b;
    d = iss.store_data;
    e = '0;
    e.is_store = (iss.opcode == OP_STORE);
    e.f3       = iss.funct3;
    e.addr     = a;
    e.reg_rd   = iss.reg_rd;
    e.index    = iss.index;
    e.pc       = iss.pc;
    case (iss.funct3[1:0])
      2'd0: begin   // byte, any address
        e.byte_en = 4'b0001 << a[1:0];
        e.wdata   = {4{d[7:0]}};
      end
      2'd1: begin
        e.mal     = a[0];
        e.byte_en = a[1] ? 4'b1100 : 4'b0011;
        e.wdata   = {2{d[15:0]}};
      end
      default: begin
        e.mal     = (a[1:0] != 2'b00);
        e.byte_en = 4'b1111;
        e.wdata   = d;
      end
    endcase
    e.wen = !e.is_store && iss.wen && !e.mal;   // loads write rd unless they fault
    return e;
  endfunction

  // little-endian pick and extension from the model memory
  function automatic logic [`WORD_W-1:0] load_value(input expect_t e);
    logic [`WORD_W-1:0] sh;
    sh = ref_mem[e.addr[7:2]] >> (8 * e.addr[1:0]);
    case (e.f3)
      3'd0:    return {{24{sh[7]}}, sh[7:0]};
      3'd1:    return {{16{sh[15]}}, sh[15:0]};
      3'd4:    return {24'd0, sh[7:0]};
      3'd5:    return {16'd0, sh[15:0]};
      default: return ref_mem[e.addr[7:2]];
    endcase
  endfunction

  task automatic apply_store(input expect_t e);
    for (int b = 0; b < 4; b++) begin
      if (e.byte_en[b]) begin
        ref_mem[e.addr[7:2]][8*b +: 8] = e.wdata[8*b +: 8];
      end
    end
  endtask

  task automatic draw_issue(output ls_issue_t iss);
    int         kind;
    logic [31:0] rnd;
    iss            = '0;
    kind           = {$random(seed)} % 100;
    rnd            = $random(seed);
    iss.ena        = ({$random(seed)} % 100) < 85;
    iss.opcode     = (kind < 45) ? OP_LOAD : (kind < 90) ? OP_STORE : OP_OTHER;
    iss.funct3     = 3'($random(seed));          // illegal values included
    iss.port_a     = {$random(seed)} & 32'hff;
    iss.port_b     = {$random(seed)} & 32'h3c;   // small word offset
    if (({$random(seed)} % 4) != 0) begin       // mostly size aligned
      if (iss.funct3[1:0] == 2'd1) iss.port_a[0] = 1'b0;
      if (iss.funct3[1:0] == 2'd2) iss.port_a[1:0] = 2'b00;
    end
    iss.store_data = $random(seed);
    iss.reg_rd     = rnd[`REG_W-1:0];
    iss.wen        = rnd[8];
    iss.index      = rnd[16 +: `CB_IDX_W];
    iss.pc         = {$random(seed)} & 32'hfffffffc;
  endtask

  // memory model, 0..3 wait states per request
  assign bus_busy  = (bus_req.ren | bus_req.wen) && (wait_left != 2'd0);
  assign bus_rdata = mem[bus_req.addr[7:2]];

  always @(negedge CLK) begin
    next_wait <= 2'($random(seed));   // drawn off the issue edge
  end

  always @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      wait_left <= 2'd0;
    end else if (bus_busy) begin
      wait_left <= wait_left - 2'd1;
    end else begin
      wait_left <= next_wait;   // arms the next request
    end
  end

  always @(posedge CLK) begin
    if (!nRST) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= fill_word(i);
      end
    end else if (bus_req.wen && !bus_busy) begin   // write lands on the completing edge
      for (int b = 0; b < 4; b++) begin
        if (bus_req.byte_en[b]) begin
          mem[bus_req.addr[7:2]][8*b +: 8] <= bus_req.wdata[8*b +: 8];
        end
      end
    end
  end

  // reference model, accepted issues and dropped latches
  always @(posedge CLK) begin
    if (nRST) begin
      if (flush || halt) begin
        dropped += exp_q.size();
        exp_q.delete();
      end else if (!busy && is_legal(issue)) begin
        exp_q.push_back(predict(issue));
      end
    end
  end

  task automatic check_bus();
    if (exp_q.size() != 0 && !exp_q[0].mal) begin
      if (bus_req.ren !== !exp_q[0].is_store || bus_req.wen !== exp_q[0].is_store)
        report_error($sformatf("pc %h ren/wen %b%b", exp_q[0].pc, bus_req.ren, bus_req.wen));
      if (bus_req.addr !== exp_q[0].addr || bus_req.byte_en !== exp_q[0].byte_en)
        report_error($sformatf("addr %h be %b, expected %h be %b", bus_req.addr,
                               bus_req.byte_en, exp_q[0].addr, exp_q[0].byte_en));
      if (exp_q[0].is_store && bus_req.wdata !== exp_q[0].wdata)
        report_error($sformatf("wdata %h, expected %h", bus_req.wdata, exp_q[0].wdata));
      if (busy !== bus_busy)
        report_error($sformatf("busy %b while bus_busy %b", busy, bus_busy));
    end else if (bus_req.ren || bus_req.wen || busy) begin
      report_error("bus request or busy with no aligned access in flight");
    end
  endtask

  task automatic check_result(input expect_t e);
    if (result.is_store !== e.is_store || result.mal_addr !== e.mal)
      report_error($sformatf("pc %h store/mal %b%b, expected %b%b", e.pc,
                             result.is_store, result.mal_addr, e.is_store, e.mal));
    if (result.index !== e.index || result.pc !== e.pc || result.wen !== e.wen)
      report_error($sformatf("pc %h idx %0d wen %b, expected pc %h idx %0d wen %b",
                             result.pc, result.index, result.wen, e.pc, e.index, e.wen));
    if (e.mal) begin
      misaligned++;
    end else if (e.is_store) begin
      stores++;
      apply_store(e);
    end else begin
      loads++;
      if (result.wdata !== load_value(e) || result.reg_rd !== e.reg_rd)
        report_error($sformatf("pc %h load x%0d=%h, expected x%0d=%h", e.pc,
                               result.reg_rd, result.wdata, e.reg_rd, load_value(e)));
    end
  endtask

  // checks on the falling edge, away from the driving edge
  always @(negedge CLK) begin
    if (!nRST) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        ref_mem[i] = fill_word(i);
      end
    end else begin
      check_bus();
      if (result.done) begin
        if (exp_q.size() == 0) begin
          report_error("done with no legal access in flight");
        end else begin
          check_result(exp_q.pop_front());
        end
        age = 0;
      end else if (exp_q.size() != 0) begin
        if (exp_q[0].mal || age == 3) begin   // misaligned is due at once, bus by 3 waits
          report_error($sformatf("no done for access at pc %h", exp_q[0].pc));
          void'(exp_q.pop_front());
          age = 0;
        end else begin
          age++;
        end
      end else begin
        age = 0;
      end
    end
  end

  initial begin
    ls_issue_t nxt;
    nRST  <= 1'b0;
    halt  <= 1'b0;
    flush <= 1'b0;
    issue <= '0;
    repeat (4) @(posedge CLK);
    nRST <= 1'b1;
    while (sent < NUM_ISSUES) begin
      @(posedge CLK);
      if (!busy) begin   // held strobe was taken, present the next
        draw_issue(nxt);
        issue <= nxt;
        if (nxt.ena) sent++;
      end
      flush <= ({$random(seed)} % 200) < 3;
      halt  <= ({$random(seed)} % 400) < 2;
    end
    do @(posedge CLK); while (busy);
    issue.ena <= 1'b0;
    flush     <= 1'b0;
    halt      <= 1'b0;
    while (exp_q.size() != 0) @(posedge CLK);
    repeat (2) @(posedge CLK);
    for (int i = 0; i < MEM_WORDS; i++) begin
      if (mem[i] !== ref_mem[i])
        report_error($sformatf("mem word %0d is %h, expected %h", i, mem[i], ref_mem[i]));
    end
    $display("issues %0d, loads %0d, stores %0d, misaligned %0d, dropped %0d, errors %0d",
             sent, loads, stores, misaligned, dropped, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(NUM_ISSUES * 8 * CLK_PERIOD);
    $display("watchdog expired before the run finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: tests/lsu_chk.sv
// bus and completion assertions bound into lsu_top in every simulation of the unit
`timescale 1ns/1ps

module lsu_chk import lsu_pkg::*; (
  input logic       CLK,
  input logic       nRST,
  input logic       halt,
  input logic       flush,
  input dbus_req_t  bus_req,
  input logic       bus_busy,
  input logic       busy,
  input ls_result_t result
);

  logic req;   // read or write on the bus

  assign req = bus_req.ren | bus_req.wen;

  one_dir: assert property (@(posedge CLK) disable iff (!nRST)
    !(bus_req.ren && bus_req.wen))
    else $error("ren and wen high in the same cycle");

  // a completion needs a finishing bus access or a faulting latch loaded one edge before
  done_src: assert property (@(posedge CLK) disable iff (!nRST)
    result.done |-> (req && !bus_busy) ||
                    (result.mal_addr && !req && $past(!busy && !flush && !halt)))
    else $error("done without a finishing request or a freshly latched misaligned access");

  // stalled request is frozen unless the latch gets cleared
  req_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (req && bus_busy && !flush && !halt) |=> $stable(bus_req))
    else $error("bus request changed while the bus was busy");

  reset_quiet: assert property (@(posedge CLK)
    !nRST |-> !(result.done || req || busy))
    else $error("done, request or busy active during reset");

endmodule

bind lsu_top lsu_chk u_chk (
  .CLK      (CLK),
  .nRST     (nRST),
  .halt     (halt),
  .flush    (flush),
  .bus_req  (bus_req),
  .bus_busy (bus_busy),
  .busy     (busy),
  .result   (result)
);

// File: src/lsu_top.sv
// top level of the load/store unit, wires decode, agu, latch and extender between issue port and data bus
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_top import lsu_pkg::*; (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               halt,
  input  logic               flush,
  input  ls_issue_t          issue,
  input  logic [`WORD_W-1:0] bus_rdata,
  input  logic               bus_busy,
  output dbus_req_t          bus_req,
  output logic               busy,
  output ls_result_t         result
);

  ls_op_t             op;         // decoded access
  ls_addr_t           addr;       // agu result
  load_t              ls_type;    // latched width for the extender
  logic [1:0]         ls_lsb;     // latched low address bits
  logic [`WORD_W-1:0] ext_data;   // extended read data

  ls_decode u_decode (
    .issue (issue),
    .op    (op)
  );

  agu u_agu (
    .port_a    (issue.port_a),
    .port_b    (issue.port_b),
    .load_type (op.load_type),
    .addr      (addr)
  );

  loadstore_unit u_lsu (
    .CLK      (CLK),
    .nRST     (nRST),
    .halt     (halt),
    .flush    (flush),
    .issue    (issue),
    .op       (op),
    .addr     (addr),
    .ext_data (ext_data),
    .bus_busy (bus_busy),
    .bus_req  (bus_req),
    .ls_type  (ls_type),
    .ls_lsb   (ls_lsb),
    .busy     (busy),
    .result   (result)
  );

  dmem_extender u_ext (
    .rdata     (bus_rdata),
    .load_type (ls_type),
    .lsb       (ls_lsb),
    .ext_out   (ext_data)
  );

endmodule

// File: src/dmem_extender.sv
// result stage of the load/store unit, picks the addressed byte or halfword and extends it
`timescale 1ns/1ps
`include "lsu_defines.svh"

module dmem_extender import lsu_pkg::*; (
  input  logic [`WORD_W-1:0] rdata,
  input  load_t              load_type,
  input  logic [1:0]         lsb,
  output logic [`WORD_W-1:0] ext_out
);

  logic [7:0]  sel_byte;   // byte at lsb
  logic [15:0] sel_half;   // halfword at lsb[1]

  // little-endian word, lane n holds bits 8n+7:8n
  always_comb begin
    case (lsb)
      2'd0:    sel_byte = rdata[7:0];
      2'd1:    sel_byte = rdata[15:8];
      2'd2:    sel_byte = rdata[23:16];
      default: sel_byte = rdata[31:24];
    endcase
  end

  assign sel_half = lsb[1] ? rdata[31:16] : rdata[15:0];

  always_comb begin
    case (load_type)
      LB:      ext_out = {{24{sel_byte[7]}}, sel_byte};    // sign
      LBU:     ext_out = {24'd0, sel_byte};
      LH:      ext_out = {{16{sel_half[15]}}, sel_half};
      LHU:     ext_out = {16'd0, sel_half};
      default: ext_out = rdata;   // word passes through
    endcase
  end

endmodule

// File: src/loadstore_unit.sv
// execute stage of the load/store unit, holds one access in the memory latch and drives the data bus
`timescale 1ns/1ps
`include "lsu_defines.svh"

module loadstore_unit import lsu_pkg::*; (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               halt,
  input  logic               flush,
  input  ls_issue_t          issue,
  input  ls_op_t             op,
  input  ls_addr_t           addr,
  input  logic [`WORD_W-1:0] ext_data,   // extended rdata from the result stage
  input  logic               bus_busy,
  output dbus_req_t          bus_req,
  output load_t              ls_type,
  output logic [1:0]         ls_lsb,
  output logic               busy,
  output ls_result_t         result
);

  // control part of the latch
  logic dren_q;
  logic dwen_q;
  logic mal_q;

  // payload part of the latch
  load_t                 load_type_q;
  logic                  wen_q;
  logic [`WORD_W-1:0]    address_q;
  logic [`BYTE_EN_W-1:0] byte_en_q;
  logic [`WORD_W-1:0]    store_data_q;
  logic [`REG_W-1:0]     reg_rd_q;
  logic [`CB_IDX_W-1:0]  index_q;
  logic [`WORD_W-1:0]    pc_q;

  logic access;      // latch holds a load or store
  logic bus_access;  // ... and it goes out on the bus
  logic stall_mem;   // bus is holding the access

  assign access     = dren_q | dwen_q;
  assign bus_access = access & ~mal_q;
  assign stall_mem  = bus_access & bus_busy;

  assign busy = stall_mem;   // issuer holds its strobe while high

  // memory latch, loads whenever the bus is not stalling it
  // an idle issue loads zero enables, so a finished access drops out here
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      dren_q <= 1'b0;
      dwen_q <= 1'b0;
      mal_q  <= 1'b0;
    end else if (flush || halt) begin
      dren_q <= 1'b0;   // dropped, no done follows
      dwen_q <= 1'b0;
      mal_q  <= 1'b0;
    end else if (!stall_mem) begin
      dren_q <= op.dren;
      dwen_q <= op.dwen;
      mal_q  <= addr.mal_addr & (op.dren | op.dwen);
    end
  end

  always_ff @(posedge CLK) begin
    if (!stall_mem) begin
      load_type_q  <= op.load_type;
      wen_q        <= op.wen;
      address_q    <= addr.address;
      byte_en_q    <= addr.byte_en;
      store_data_q <= issue.store_data;
      reg_rd_q     <= issue.reg_rd;
      index_q      <= issue.index;
      pc_q         <= issue.pc;
    end
  end

  // bus drive, misaligned accesses never leave the unit
  assign bus_req.ren     = dren_q & ~mal_q;
  assign bus_req.wen     = dwen_q & ~mal_q;
  assign bus_req.addr    = address_q;
  assign bus_req.byte_en = byte_en_q;

  // replicate store data so the byte lanes pick the right copy
  always_comb begin
    case (load_type_q)
      LB, LBU: bus_req.wdata = {4{store_data_q[7:0]}};
      LH, LHU: bus_req.wdata = {2{store_data_q[15:0]}};
      default: bus_req.wdata = store_data_q;
    endcase
  end

  // extender side
  assign ls_type = load_type_q;
  assign ls_lsb  = address_q[1:0];

  // completion broadcast
  assign result.done     = access & (mal_q | ~bus_busy);   // one cycle per access
  assign result.is_store = dwen_q;
  assign result.wen      = wen_q & dren_q & ~mal_q;        // no rd write on a fault
  assign result.reg_rd   = reg_rd_q;
  assign result.wdata    = dren_q ? ext_data : '0;
  assign result.index    = index_q;
  assign result.pc       = pc_q;
  assign result.mal_addr = mal_q;

endmodule

// File: src/agu.sv
// address generation for the load/store unit, effective address, byte lanes and misalignment check
`timescale 1ns/1ps
`include "lsu_defines.svh"

module agu import lsu_pkg::*; (
  input  logic [`WORD_W-1:0] port_a,
  input  logic [`WORD_W-1:0] port_b,
  input  load_t              load_type,
  output ls_addr_t           addr
);

  logic [`WORD_W-1:0] eff_addr;   // base plus offset
  logic [1:0]         lsb;        // byte within the word

  assign eff_addr = port_a + port_b;
  assign lsb      = eff_addr[1:0];

  assign addr.address = eff_addr;

  // little-endian lanes, byte 0 sits in bits 7:0
  always_comb begin
    addr.byte_en = 4'b0000;
    case (load_type)
      LB, LBU: addr.byte_en = 4'b0001 << lsb;
      LH, LHU: addr.byte_en = lsb[1] ? 4'b1100 : 4'b0011;
      LW:      addr.byte_en = 4'b1111;
      default: addr.byte_en = 4'b0000;
    endcase
  end

  // halfwords need even addresses, words a multiple of four
  always_comb begin
    case (load_type)
      LH, LHU: addr.mal_addr = lsb[0];
      LW:      addr.mal_addr = |lsb;
      default: addr.mal_addr = 1'b0;   // bytes go anywhere
    endcase
  end

endmodule

// File: src/ls_decode.sv
// decode stage of the load/store unit, turns the issued opcode and funct3 into access type and enables
`timescale 1ns/1ps

module ls_decode import lsu_pkg::*; (
  input  ls_issue_t issue,
  output ls_op_t    op
);

  logic is_load;    // valid load strobe
  logic is_store;   // valid store strobe
  logic ld_ok;      // funct3 usable by a load
  logic st_ok;      // funct3 usable by a store

  assign is_load  = issue.ena && (issue.opcode == OP_LOAD);
  assign is_store = issue.ena && (issue.opcode == OP_STORE);

  // legal funct3 sets per access kind
  always_comb begin
    ld_ok = 1'b0;
    st_ok = 1'b0;
    case (issue.funct3)
      3'b000, 3'b001, 3'b010: begin
        ld_ok = 1'b1;
        st_ok = 1'b1;
      end
      3'b100, 3'b101: begin
        ld_ok = 1'b1;   // unsigned loads have no store twin
      end
      default: begin
        ld_ok = 1'b0;
        st_ok = 1'b0;
      end
    endcase
  end

  always_comb begin
    op.dren      = 1'b0;
    op.dwen      = 1'b0;
    op.wen       = 1'b0;
    op.load_type = LW;        // harmless default for the agu
    op.illegal   = 1'b0;
    if (is_load) begin
      op.dren    = ld_ok;
      op.wen     = issue.wen & ld_ok;   // rd write follows the issue
      op.illegal = ~ld_ok;
      if (ld_ok) begin
        op.load_type = load_t'(issue.funct3);
      end
    end else if (is_store) begin
      op.dwen    = st_ok;
      op.illegal = ~st_ok;    // stores never write a register
      if (st_ok) begin
        op.load_type = load_t'(issue.funct3);
      end
    end
  end

endmodule

// File: src/lsu_pkg.sv
// shared enums and packed structs of the load/store unit, imported by the RTL and the testbench
`include "lsu_defines.svh"

package lsu_pkg;

  // only the memory opcodes matter here, the rest map to OP_OTHER
  typedef enum logic [6:0] {
    OP_LOAD  = `OPC_LOAD,
    OP_STORE = `OPC_STORE,
    OP_OTHER = `OPC_ALUI
  } opcode_t;

  // encodings follow funct3, stores reuse LB/LH/LW for their width
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } load_t;

  typedef struct packed {
    logic                  ena;        // single-cycle issue strobe
    opcode_t               opcode;
    logic [2:0]            funct3;
    logic [`WORD_W-1:0]    port_a;     // base register
    logic [`WORD_W-1:0]    port_b;     // sign-extended offset
    logic [`WORD_W-1:0]    store_data;
    logic [`REG_W-1:0]     reg_rd;
    logic                  wen;        // register write for loads
    logic [`CB_IDX_W-1:0]  index;      // completion buffer slot
    logic [`WORD_W-1:0]    pc;
  } ls_issue_t;

  typedef struct packed {
    logic  dren;
    logic  dwen;
    logic  wen;
    load_t load_type;
    logic  illegal;   // load/store with a funct3 it cannot use
  } ls_op_t;

  typedef struct packed {
    logic [`WORD_W-1:0]    address;
    logic [`BYTE_EN_W-1:0] byte_en;
    logic                  mal_addr;
  } ls_addr_t;

  typedef struct packed {
    logic                  ren;
    logic                  wen;
    logic [`WORD_W-1:0]    addr;
    logic [`WORD_W-1:0]    wdata;
    logic [`BYTE_EN_W-1:0] byte_en;
  } dbus_req_t;

  typedef struct packed {
    logic                 done;      // one-cycle completion pulse
    logic                 is_store;
    logic                 wen;
    logic [`REG_W-1:0]    reg_rd;
    logic [`WORD_W-1:0]   wdata;     // extended load data
    logic [`CB_IDX_W-1:0] index;
    logic [`WORD_W-1:0]   pc;
    logic                 mal_addr;
  } ls_result_t;

endpackage

// File: include/lsu_defines.svh
// width and depth macros for the load/store unit, included by the package and the RTL modules
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// data path and address width of the core
`define WORD_W 32

// architectural register index, x0..x31
`define REG_W 5

// completion buffer entries tracked per in-flight instruction
`define NUM_CB_ENTRY 8

// index into the completion buffer
`define CB_IDX_W $clog2(`NUM_CB_ENTRY)

// bytes per bus word, one byte enable each
`define BYTE_EN_W (`WORD_W / 8)

// rv32i major opcodes seen by the unit
`define OPC_LOAD  7'b0000011
`define OPC_STORE 7'b0100011
`define OPC_ALUI  7'b0010011

`endif
